// ==== hdl/fp_pkg.sv ====
/*
 * IEEE-754 single-precision format constants for the MAC pipeline.
 * Holds field widths, the exponent bias and normal range, and the
 * widths of the internal wide mantissa and signed exponent.
 * Stages refer to these by scoped name.
 */
`default_nettype none

package fp_pkg;

    // Stored format
    localparam int EXP_W  = 8;   // Biased exponent field
    localparam int FRAC_W = 23;  // Stored fraction, hidden bit not included
    localparam int MANT_W = 24;  // Fraction plus hidden bit

    localparam int BIAS = 127;

    // Normal range of the biased exponent
    // All ones is inf/NaN and zero is zero/denormal
    localparam int EXP_MAX = 254;
    localparam int EXP_MIN = 1;

    // Internal wide mantissa
    // A full 24x24 product, kept normalised with the leading one at
    // bit PROD_W-2 so bit PROD_W-1 is free for an add carry
    localparam int PROD_W = 2 * MANT_W;

    // Signed internal exponent, room for overflow and underflow
    localparam int SEXP_W = 10;

endpackage

`default_nettype wire

// ==== hdl/mac_pkg.sv ====
/*
 * Dot-product grouping for the MAC cell.
 * DOT_LEN products are summed into one result before the
 * accumulator clears; CNT_W is the width of the group counter.
 */
`default_nettype none

package mac_pkg;

    localparam int DOT_LEN = 4;  // Products per emitted result

    // One extra bit so the counter can hold DOT_LEN itself
    localparam int CNT_W = $clog2(DOT_LEN) + 1;

endpackage

`default_nettype wire

// ==== hdl/fma_operand_check.sv ====
/*
 * First pipeline stage of the MAC cell.
 * Registers an accepted operand pair and flags the pair as bad when
 * either operand is infinite, NaN or denormal.
 */
`timescale 1ns/10ps
`default_nettype none

module fma_operand_check (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] in_a,
    input  logic [31:0] in_b,
    output logic        in_ready,
    output logic        chk_valid,
    output logic [31:0] chk_a,
    output logic [31:0] chk_b,
    output logic        chk_bad,
    input  logic        chk_ready
);

    // Exponent all ones, or zero exponent with a nonzero fraction
    function automatic logic is_special(input logic [31:0] f);
        logic [fp_pkg::EXP_W-1:0]  e;
        logic [fp_pkg::FRAC_W-1:0] m;
        e = f[fp_pkg::FRAC_W +: fp_pkg::EXP_W];
        m = f[fp_pkg::FRAC_W-1:0];
        return (&e) || ((e == '0) && (m != '0));
    endfunction

    assign in_ready = !chk_valid || chk_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            chk_valid <= 1'b0;
        end else if (in_ready) begin
            chk_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            chk_a   <= in_a;
            chk_b   <= in_b;
            chk_bad <= is_special(in_a) || is_special(in_b);
        end
    end

    // A stalled pair must reach the multiplier unchanged
    assert property (@(posedge clk) disable iff (rst)
        chk_valid && !chk_ready |=> chk_valid && $stable(chk_a) && $stable(chk_b))
        else $error("operand pair changed while stalled");

endmodule

`default_nettype wire

// ==== hdl/fma_multiply.sv ====
/*
 * Second pipeline stage of the MAC cell.
 * Multiplies the two mantissas, adds the exponents and brings a
 * product of 2.0 or more back into range with one right shift.
 * A zero operand gives a zero product.
 */
`timescale 1ns/10ps
`default_nettype none

module fma_multiply (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             chk_valid,
    input  logic [31:0]                      chk_a,
    input  logic [31:0]                      chk_b,
    input  logic                             chk_bad,
    output logic                             chk_ready,
    output logic                             mul_valid,
    output logic                             mul_sign,
    output logic signed [fp_pkg::SEXP_W-1:0] mul_exp,
    output logic [fp_pkg::PROD_W-1:0]        mul_mant,
    output logic                             mul_zero,
    output logic                             mul_bad,
    input  logic                             mul_ready
);

    logic [fp_pkg::EXP_W-1:0]         exp_a;
    logic [fp_pkg::EXP_W-1:0]         exp_b;
    logic [fp_pkg::MANT_W-1:0]        mant_a;
    logic [fp_pkg::MANT_W-1:0]        mant_b;
    logic [fp_pkg::PROD_W-1:0]        prod_raw;
    logic signed [fp_pkg::SEXP_W-1:0] exp_sum;
    logic                             any_zero;
    logic                             nxt_sign;
    logic signed [fp_pkg::SEXP_W-1:0] nxt_exp;
    logic [fp_pkg::PROD_W-1:0]        nxt_mant;

    assign exp_a  = chk_a[fp_pkg::FRAC_W +: fp_pkg::EXP_W];
    assign exp_b  = chk_b[fp_pkg::FRAC_W +: fp_pkg::EXP_W];
    assign mant_a = {1'b1, chk_a[fp_pkg::FRAC_W-1:0]};  // Hidden bit restored
    assign mant_b = {1'b1, chk_b[fp_pkg::FRAC_W-1:0]};

    assign any_zero = (chk_a[30:0] == '0) || (chk_b[30:0] == '0);

    always_comb begin
        prod_raw = mant_a * mant_b;
        exp_sum  = fp_pkg::SEXP_W'(exp_a) + fp_pkg::SEXP_W'(exp_b)
                 - fp_pkg::SEXP_W'(fp_pkg::BIAS);
        nxt_sign = chk_a[31] ^ chk_b[31];
        if (any_zero) begin
            nxt_sign = 1'b0;
            nxt_exp  = '0;
            nxt_mant = '0;
        end else if (prod_raw[fp_pkg::PROD_W-1]) begin  // Product in [2.0, 4.0)
            nxt_exp  = exp_sum + 2'sd1;
            nxt_mant = prod_raw >> 1;
        end else begin
            nxt_exp  = exp_sum;
            nxt_mant = prod_raw;
        end
    end

    assign chk_ready = !mul_valid || mul_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_valid <= 1'b0;
        end else if (chk_ready) begin
            mul_valid <= chk_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (chk_valid && chk_ready) begin
            mul_sign <= nxt_sign;
            mul_exp  <= nxt_exp;
            mul_mant <= nxt_mant;
            mul_zero <= any_zero;
            mul_bad  <= chk_bad;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fma_accumulate.sv ====
/*
 * Third pipeline stage of the MAC cell.
 * Aligns each product against the running sum, adds or subtracts the
 * mantissas and renormalises, all in one cycle. The last product of a
 * group loads the finished sum into the output register and clears it.
 */
`timescale 1ns/10ps
`default_nettype none

module fma_accumulate (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             mul_valid,
    input  logic                             mul_sign,
    input  logic signed [fp_pkg::SEXP_W-1:0] mul_exp,
    input  logic [fp_pkg::PROD_W-1:0]        mul_mant,
    input  logic                             mul_zero,
    input  logic                             mul_bad,
    output logic                             mul_ready,
    output logic                             sum_valid,
    output logic                             sum_sign,
    output logic signed [fp_pkg::SEXP_W-1:0] sum_exp,
    output logic [fp_pkg::PROD_W-1:0]        sum_mant,
    output logic                             sum_zero,
    output logic                             sum_bad,
    input  logic                             sum_ready
);

    // Running sum
    logic                             acc_sign;
    logic signed [fp_pkg::SEXP_W-1:0] acc_exp;
    logic [fp_pkg::PROD_W-1:0]        acc_mant;
    logic                             acc_zero;
    logic                             acc_bad;
    logic [mac_pkg::CNT_W-1:0]        cnt;  // Products absorbed so far

    logic                             big_sign;
    logic                             small_sign;
    logic signed [fp_pkg::SEXP_W-1:0] big_exp;
    logic signed [fp_pkg::SEXP_W-1:0] small_exp;
    logic [fp_pkg::PROD_W-1:0]        big_mant;
    logic [fp_pkg::PROD_W-1:0]        small_mant;
    logic [fp_pkg::SEXP_W:0]          diff;  // One bit wider, never overflows
    logic [fp_pkg::PROD_W-1:0]        aligned;
    logic [fp_pkg::PROD_W-1:0]        raw;
    logic                             raw_sign;
    logic signed [fp_pkg::SEXP_W-1:0] lshift;

    logic                             nxt_sign;
    logic signed [fp_pkg::SEXP_W-1:0] nxt_exp;
    logic [fp_pkg::PROD_W-1:0]        nxt_mant;
    logic                             nxt_zero;
    logic                             last;

    function automatic logic [fp_pkg::SEXP_W-1:0] lead_one(input logic [fp_pkg::PROD_W-1:0] m);
        logic [fp_pkg::SEXP_W-1:0] pos;
        pos = '0;
        for (int i = 0; i < fp_pkg::PROD_W; i++) begin
            if (m[i]) begin
                pos = fp_pkg::SEXP_W'(i);
            end
        end
        return pos;
    endfunction

    always_comb begin
        // Operand with the larger exponent stays put
        if (acc_exp >= mul_exp) begin
            {big_sign, big_exp, big_mant}       = {acc_sign, acc_exp, acc_mant};
            {small_sign, small_exp, small_mant} = {mul_sign, mul_exp, mul_mant};
        end else begin
            {big_sign, big_exp, big_mant}       = {mul_sign, mul_exp, mul_mant};
            {small_sign, small_exp, small_mant} = {acc_sign, acc_exp, acc_mant};
        end
        diff    = {big_exp[fp_pkg::SEXP_W-1], big_exp} - {small_exp[fp_pkg::SEXP_W-1], small_exp};
        aligned = (diff >= fp_pkg::PROD_W) ? '0 : small_mant >> diff;

        // Magnitude add or subtract
        if (big_sign == small_sign) begin
            raw      = big_mant + aligned;
            raw_sign = big_sign;
        end else if (big_mant >= aligned) begin
            raw      = big_mant - aligned;
            raw_sign = big_sign;
        end else begin
            raw      = aligned - big_mant;  // Only when the exponents match
            raw_sign = small_sign;
        end

        lshift = fp_pkg::SEXP_W'(fp_pkg::PROD_W - 2) - lead_one(raw);

        if (acc_zero) begin  // Empty sum takes the product as is
            {nxt_sign, nxt_exp, nxt_mant, nxt_zero} = {mul_sign, mul_exp, mul_mant, mul_zero};
        end else if (raw == '0) begin
            {nxt_sign, nxt_exp, nxt_mant, nxt_zero} = {1'b0, {fp_pkg::SEXP_W{1'b0}},
                                                       {fp_pkg::PROD_W{1'b0}}, 1'b1};
        end else if (raw[fp_pkg::PROD_W-1]) begin  // Carry out of the add
            {nxt_sign, nxt_exp, nxt_mant, nxt_zero} = {raw_sign, big_exp + 2'sd1,
                                                       raw >> 1, 1'b0};
        end else begin
            {nxt_sign, nxt_exp, nxt_mant, nxt_zero} = {raw_sign, big_exp - lshift,
                                                       raw << lshift, 1'b0};
        end
    end

    assign mul_ready = !sum_valid || sum_ready;
    assign last      = (cnt == mac_pkg::CNT_W'(mac_pkg::DOT_LEN - 1));

    always_ff @(posedge clk) begin
        if (rst || (mul_valid && mul_ready && last)) begin  // Clear at group end
            acc_sign <= 1'b0;
            acc_exp  <= '0;
            acc_mant <= '0;
            acc_zero <= 1'b1;
            acc_bad  <= 1'b0;
            cnt      <= '0;
        end else if (mul_valid && mul_ready) begin
            acc_sign <= nxt_sign;
            acc_exp  <= nxt_exp;
            acc_mant <= nxt_mant;
            acc_zero <= nxt_zero;
            acc_bad  <= acc_bad || mul_bad;
            cnt      <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else if (mul_valid && mul_ready && last) begin
            sum_valid <= 1'b1;
        end else if (sum_ready) begin
            sum_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_valid && mul_ready && last) begin
            sum_sign <= nxt_sign;
            sum_exp  <= nxt_exp;
            sum_mant <= nxt_mant;
            sum_zero <= nxt_zero;
            sum_bad  <= acc_bad || mul_bad;  // Bad flag ORs across the group
        end
    end

    assert property (@(posedge clk) disable iff (rst) cnt <= mac_pkg::DOT_LEN)
        else $error("group count beyond DOT_LEN");

    // Multiplier and accumulator together keep the sum normalised
    assert property (@(posedge clk) disable iff (rst)
        sum_valid && !sum_zero |-> sum_mant[fp_pkg::PROD_W-2])
        else $error("finished sum not normalised");

endmodule

`default_nettype wire

// ==== hdl/fma_result.sv ====
/*
 * Last pipeline stage of the MAC cell.
 * Packs a finished group sum to single precision by truncation and
 * flags bad groups and out-of-range exponents with an all-ones result.
 * The packed result holds until out_ready.
 */
`timescale 1ns/10ps
`default_nettype none

module fma_result (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             sum_valid,
    input  logic                             sum_sign,
    input  logic signed [fp_pkg::SEXP_W-1:0] sum_exp,
    input  logic [fp_pkg::PROD_W-1:0]        sum_mant,
    input  logic                             sum_zero,
    input  logic                             sum_bad,
    output logic                             sum_ready,
    output logic                             out_valid,
    output logic [31:0]                      out_result,
    output logic                             out_error,
    input  logic                             out_ready
);

    logic        out_of_range;
    logic [31:0] nxt_result;
    logic        nxt_error;

    assign out_of_range = (sum_exp > fp_pkg::EXP_MAX) || (sum_exp < fp_pkg::EXP_MIN);

    always_comb begin
        if (sum_bad || (!sum_zero && out_of_range)) begin
            nxt_result = '1;
            nxt_error  = 1'b1;
        end else if (sum_zero) begin
            nxt_result = '0;
            nxt_error  = 1'b0;
        end else begin
            // Fraction sits just below the leading one at bit PROD_W-2
            nxt_result = {sum_sign, sum_exp[fp_pkg::EXP_W-1:0],
                          sum_mant[fp_pkg::PROD_W-3 -: fp_pkg::FRAC_W]};
            nxt_error  = 1'b0;
        end
    end

    assign sum_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (sum_ready) begin
            out_valid <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid && sum_ready) begin
            out_result <= nxt_result;
            out_error  <= nxt_error;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && out_error |-> (&out_result))
        else $error("error result is not all ones");

endmodule

`default_nettype wire

// ==== hdl/fma_cell.sv ====
/*
 * Single-precision multiply-accumulate cell, top level.
 * Chains check, multiply, accumulate and result stages over valid/ready
 * links; one dot-product result leaves per group of operand pairs.
 */
`timescale 1ns/10ps
`default_nettype none

module fma_cell (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] in_a,
    input  logic [31:0] in_b,
    output logic        in_ready,
    output logic        out_valid,
    output logic [31:0] out_result,
    output logic        out_error,
    input  logic        out_ready
);

    // Check to multiply
    logic        chk_valid;
    logic        chk_ready;
    logic [31:0] chk_a;
    logic [31:0] chk_b;
    logic        chk_bad;

    // Multiply to accumulate
    logic                             mul_valid;
    logic                             mul_ready;
    logic                             mul_sign;
    logic signed [fp_pkg::SEXP_W-1:0] mul_exp;
    logic [fp_pkg::PROD_W-1:0]        mul_mant;
    logic                             mul_zero;
    logic                             mul_bad;

    // Accumulate to result, finished sums only
    logic                             sum_valid;
    logic                             sum_ready;
    logic                             sum_sign;
    logic signed [fp_pkg::SEXP_W-1:0] sum_exp;
    logic [fp_pkg::PROD_W-1:0]        sum_mant;
    logic                             sum_zero;
    logic                             sum_bad;

    fma_operand_check u_check (
        .clk, .rst, .in_valid, .in_a, .in_b, .in_ready,
        .chk_valid, .chk_a, .chk_b, .chk_bad, .chk_ready
    );

    fma_multiply u_multiply (
        .clk, .rst, .chk_valid, .chk_a, .chk_b, .chk_bad, .chk_ready,
        .mul_valid, .mul_sign, .mul_exp, .mul_mant, .mul_zero, .mul_bad, .mul_ready
    );

    fma_accumulate u_accumulate (
        .clk, .rst,
        .mul_valid, .mul_sign, .mul_exp, .mul_mant, .mul_zero, .mul_bad, .mul_ready,
        .sum_valid, .sum_sign, .sum_exp, .sum_mant, .sum_zero, .sum_bad, .sum_ready
    );

    fma_result u_result (
        .clk, .rst,
        .sum_valid, .sum_sign, .sum_exp, .sum_mant, .sum_zero, .sum_bad, .sum_ready,
        .out_valid, .out_result, .out_error, .out_ready
    );

endmodule

`default_nettype wire

// ==== test/fma_ref.svh ====
/*
 * Reference model and stimulus helpers for the MAC cell testbench.
 * dot_ref gives a group's expected {error, result} by the check, multiply,
 * accumulate and pack rules. Included at file scope by the testbench.
 */
`ifndef FMA_REF_SVH
`define FMA_REF_SVH

// Galois LFSR step, right shifting, taps 32 31 29 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'hD000_0001;
    end
    return state >> 1;
endfunction

function automatic logic [31:0] fp_bits(input logic sign, input logic [7:0] exp,
                                        input logic [22:0] frac);
    return {sign, exp, frac};
endfunction

// Infinity, NaN or denormal
function automatic logic operand_bad(input logic [31:0] f);
    if (f[30:23] == 8'hFF) begin
        return 1'b1;
    end
    return (f[30:23] == 8'h00) && (f[22:0] != 23'h0);
endfunction

function automatic logic [32:0] dot_ref(input logic [mac_pkg::DOT_LEN-1:0][31:0] a,
                                        input logic [mac_pkg::DOT_LEN-1:0][31:0] b);
    logic        bad;
    logic        acc_zero;
    logic        acc_sign;
    int          acc_exp;
    logic [47:0] acc_mant;
    logic        p_sign;
    int          p_exp;
    logic [47:0] p_mant;
    logic        acc_big;
    int          shift;
    logic [47:0] hi_mant;
    logic [47:0] lo_mant;
    logic        hi_sign;
    logic        lo_sign;
    logic [47:0] raw;
    logic        raw_sign;
    bad      = 1'b0;
    acc_zero = 1'b1;
    acc_sign = 1'b0;
    acc_exp  = 0;
    acc_mant = '0;
    for (int i = 0; i < mac_pkg::DOT_LEN; i++) begin
        bad = bad | operand_bad(a[i]) | operand_bad(b[i]);
        if (a[i][30:0] == 31'h0 || b[i][30:0] == 31'h0) begin
            p_sign = 1'b0;  // Zero product
            p_exp  = 0;
            p_mant = '0;
        end else begin
            p_sign = a[i][31] ^ b[i][31];
            p_exp  = int'(a[i][30:23]) + int'(b[i][30:23]) - fp_pkg::BIAS;
            p_mant = {24'h0, 1'b1, a[i][22:0]} * {24'h0, 1'b1, b[i][22:0]};
            if (p_mant[47]) begin
                p_mant = p_mant >> 1;
                p_exp  = p_exp + 1;
            end
        end
        if (acc_zero) begin
            acc_zero = (p_mant == '0);
            acc_sign = p_sign;
            acc_exp  = p_exp;
            acc_mant = p_mant;
        end else begin
            // Smaller exponent gets shifted
            acc_big = (acc_exp >= p_exp);
            shift   = acc_big ? acc_exp - p_exp : p_exp - acc_exp;
            hi_mant = acc_big ? acc_mant : p_mant;
            hi_sign = acc_big ? acc_sign : p_sign;
            lo_mant = acc_big ? p_mant : acc_mant;
            lo_sign = acc_big ? p_sign : acc_sign;
            lo_mant = (shift >= 48) ? 48'h0 : lo_mant >> shift;
            acc_exp = acc_big ? acc_exp : p_exp;
            if (hi_sign == lo_sign) begin
                raw      = hi_mant + lo_mant;
                raw_sign = hi_sign;
            end else if (hi_mant >= lo_mant) begin
                raw      = hi_mant - lo_mant;
                raw_sign = hi_sign;
            end else begin
                raw      = lo_mant - hi_mant;
                raw_sign = lo_sign;
            end
            if (raw == '0) begin
                acc_zero = 1'b1;
                acc_sign = 1'b0;
                acc_exp  = 0;
                acc_mant = '0;
            end else begin
                if (raw[47]) begin
                    raw     = raw >> 1;
                    acc_exp = acc_exp + 1;
                end
                while (!raw[46]) begin  // Leading one back to bit 46
                    raw     = raw << 1;
                    acc_exp = acc_exp - 1;
                end
                acc_sign = raw_sign;
                acc_mant = raw;
            end
        end
    end
    if (bad) begin
        return {1'b1, 32'hFFFF_FFFF};
    end
    if (acc_zero) begin
        return 33'h0;
    end
    if (acc_exp > fp_pkg::EXP_MAX || acc_exp < fp_pkg::EXP_MIN) begin
        return {1'b1, 32'hFFFF_FFFF};
    end
    return {1'b0, acc_sign, acc_exp[7:0], acc_mant[45:23]};
endfunction

`endif

// ==== test/fma_cell_tb.sv ====
/*
 * Testbench for the single-precision MAC cell.
 * Sends operand pairs in groups, checks every dot-product result against
 * the reference model and prints one line per test and a closing count.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fma_ref.svh"

module fma_cell_tb;

    localparam int TIMEOUT_CYCLES = 2000;

    localparam logic [31:0] F_ZERO    = 32'h0000_0000;
    localparam logic [31:0] F_NZERO   = 32'h8000_0000;
    localparam logic [31:0] F_QUARTER = 32'h3E80_0000;
    localparam logic [31:0] F_HALF    = 32'h3F00_0000;
    localparam logic [31:0] F_ONE     = 32'h3F80_0000;
    localparam logic [31:0] F_NONE    = 32'hBF80_0000;
    localparam logic [31:0] F_1P5     = 32'h3FC0_0000;
    localparam logic [31:0] F_TWO     = 32'h4000_0000;
    localparam logic [31:0] F_NTWO    = 32'hC000_0000;
    localparam logic [31:0] F_THREE   = 32'h4040_0000;
    localparam logic [31:0] F_FOUR    = 32'h4080_0000;
    localparam logic [31:0] F_NFOUR   = 32'hC080_0000;
    localparam logic [31:0] F_HUGE    = 32'h7E80_0000;  // 2^126
    localparam logic [31:0] F_TINY    = 32'h0D80_0000;  // 2^-100
    localparam logic [31:0] F_INF     = 32'h7F80_0000;
    localparam logic [31:0] F_NINF    = 32'hFF80_0000;
    localparam logic [31:0] F_NAN     = 32'h7FC0_0000;
    localparam logic [31:0] F_DENORM  = 32'h0000_0001;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_a;
    logic [31:0] in_b;
    logic        in_ready;
    logic        out_valid;
    logic [31:0] out_result;
    logic        out_error;
    logic        out_ready;

    logic [63:0] pending_q[$];  // Pairs sent, {a, b}
    logic [31:0] stim_lfsr;
    logic [31:0] bp_lfsr;
    logic [31:0] bp_bits;
    logic        bp_on;
    logic        was_stalled;
    logic [31:0] held_result;
    logic        held_error;
    logic        timed_out;
    int          groups_sent;
    int          results_seen;
    int          check_count;
    int          error_count;
    int          stall_cycles;
    int          test_count;

    fma_cell u_fma_cell (
        .clk, .rst, .in_valid, .in_a, .in_b, .in_ready,
        .out_valid, .out_result, .out_error, .out_ready
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Later waits are skipped once one has timed out
    task automatic flag_timeout(input string why);
        $display("%s", why);
        error_count++;
        timed_out = 1'b1;
    endtask

    task automatic take_bits(input int n, inout logic [31:0] state, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits  = {bits[30:0], state[0]};
            state = lfsr_next(state);
        end
    endtask

    // Normal operand, exponent kept near the bias so sums stay in range
    task automatic random_operand(output logic [31:0] f);
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] m;
        take_bits(1, stim_lfsr, s);
        take_bits(5, stim_lfsr, e);
        take_bits(23, stim_lfsr, m);
        f = fp_bits(s[0], 8'(112 + e), m[22:0]);
    endtask

    // Called 1 ns after a rising edge, returns at the same point
    task automatic send_pair(input logic [31:0] a, input logic [31:0] b);
        int waited;
        if (!timed_out) begin
            in_valid = 1'b1;
            in_a     = a;
            in_b     = b;
            waited   = 0;
            @(negedge clk);
            while (!in_ready && waited < TIMEOUT_CYCLES) begin
                waited++;
                @(negedge clk);
            end
            if (!in_ready) begin
                flag_timeout("Timed out waiting for in_ready");
            end else begin
                pending_q.push_back({a, b});
                @(posedge clk);
                #1;
                in_valid = 1'b0;
            end
        end
    endtask

    task automatic send_group(input logic [mac_pkg::DOT_LEN-1:0][31:0] a,
                              input logic [mac_pkg::DOT_LEN-1:0][31:0] b);
        for (int i = 0; i < mac_pkg::DOT_LEN; i++) begin
            send_pair(a[i], b[i]);
        end
        groups_sent++;
    endtask

    task automatic random_group();
        logic [mac_pkg::DOT_LEN-1:0][31:0] a;
        logic [mac_pkg::DOT_LEN-1:0][31:0] b;
        logic [31:0]                       f;
        for (int i = 0; i < mac_pkg::DOT_LEN; i++) begin
            random_operand(f);
            a[i] = f;
            random_operand(f);
            b[i] = f;
        end
        send_group(a, b);
    endtask

    // Returns 1 ns after a rising edge, ready for the next send
    task automatic wait_results();
        int waited;
        waited = 0;
        while (!timed_out && results_seen < groups_sent && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!timed_out && results_seen < groups_sent) begin
            flag_timeout("Timed out waiting for dot-product results");
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        test_count++;
        if (pending_q.size() != 0) begin
            $display("%s left %0d pairs without a result", name, pending_q.size());
            error_count++;
        end
        $display("Test %0d %s: %s, %0d errors", test_count, name,
                 (error_count == err_before) ? "ok" : "failed", error_count - err_before);
    endtask

    task automatic check_result();
        logic [mac_pkg::DOT_LEN-1:0][31:0] a;
        logic [mac_pkg::DOT_LEN-1:0][31:0] b;
        logic [63:0]                       pair;
        logic [32:0]                       expected;
        results_seen++;
        if (pending_q.size() < mac_pkg::DOT_LEN) begin
            $display("A result arrived with no complete group of pairs pending");
            error_count++;
        end else begin
            for (int i = 0; i < mac_pkg::DOT_LEN; i++) begin
                pair = pending_q.pop_front();
                a[i] = pair[63:32];
                b[i] = pair[31:0];
            end
            expected = dot_ref(a, b);
            check_count++;
            if (out_result !== expected[31:0]) begin
                $display("ERR out_result: got %h, expected %h", out_result, expected[31:0]);
                error_count++;
            end
            if (out_error !== expected[32]) begin
                $display("ERR out_error: got %h, expected %h", out_error, expected[32]);
                error_count++;
            end
        end
    endtask

    // Compare process, samples mid-cycle
    initial begin
        was_stalled = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (was_stalled && (!out_valid || out_result !== held_result
                                    || out_error !== held_error)) begin
                    $display("The held result changed or vanished while out_ready was low");
                    error_count++;
                end
                if (out_valid && out_ready) begin
                    check_result();
                end
                if (bp_on && in_valid && !in_ready) begin
                    stall_cycles++;
                end
                was_stalled = out_valid && !out_ready;
                held_result = out_result;
                held_error  = out_error;
            end
        end
    end

    // out_ready, random only while back-pressure is on
    initial begin
        out_ready = 1'b1;
        bp_lfsr   = 32'h3573;
        forever begin
            @(posedge clk);
            #1;
            if (bp_on) begin
                take_bits(3, bp_lfsr, bp_bits);
                out_ready = &bp_bits[2:0];  // Mostly low so the pipeline fills
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        logic [mac_pkg::DOT_LEN-1:0][31:0] a;
        logic [mac_pkg::DOT_LEN-1:0][31:0] b;
        logic [mac_pkg::DOT_LEN-1:0][31:0] specials;
        int                                err0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_a         = '0;
        in_b         = '0;
        bp_on        = 1'b0;
        timed_out    = 1'b0;
        stim_lfsr    = 32'h3573;
        groups_sent  = 0;
        results_seen = 0;
        check_count  = 0;
        error_count  = 0;
        stall_cycles = 0;
        test_count   = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
            $display("ERR in_ready/out_valid after reset: got %h/%h, expected 1/0",
                     in_ready, out_valid);
            error_count++;
        end
        @(posedge clk);
        #1;

        err0 = error_count;
        send_group({F_THREE, F_1P5, F_HALF, F_ONE}, {F_ONE, F_TWO, F_FOUR, F_TWO});
        send_group({F_FOUR, F_HALF, F_ONE, F_NTWO}, {F_QUARTER, F_HALF, F_ONE, F_ONE});
        send_group({F_HALF, F_TWO, F_ONE, F_1P5}, {F_HALF, F_HALF, F_ONE, F_1P5});
        wait_results();
        report_test("exact values", err0);

        err0 = error_count;
        repeat (50) random_group();
        wait_results();
        report_test("random groups", err0);

        err0 = error_count;
        send_group({F_ZERO, F_ZERO, F_ONE, F_ZERO}, {F_ONE, F_ZERO, F_NZERO, F_TWO});
        send_group({F_NONE, F_ONE, F_NTWO, F_TWO}, {F_ONE, F_ONE, F_THREE, F_THREE});
        send_group({F_ONE, F_ZERO, F_NFOUR, F_TWO}, {F_HALF, F_ONE, F_TWO, F_THREE});
        send_group({F_HALF, F_TWO, F_NONE, F_ONE}, {F_ONE, F_TWO, F_ONE, F_ONE});
        wait_results();
        report_test("zeros and cancellation", err0);

        // One special value per position, each followed by a clean group
        err0     = error_count;
        specials = {F_DENORM, F_NAN, F_NINF, F_INF};
        for (int pos = 0; pos < mac_pkg::DOT_LEN; pos++) begin
            for (int i = 0; i < mac_pkg::DOT_LEN; i++) begin
                a[i] = F_ONE;
                b[i] = F_TWO;
            end
            if (pos % 2 == 0) begin
                a[pos] = specials[pos];
            end else begin
                b[pos] = specials[pos];
            end
            send_group(a, b);
            random_group();
        end
        wait_results();
        report_test("special inputs", err0);

        err0 = error_count;
        send_group({F_HUGE, F_HUGE, F_HUGE, F_HUGE}, {F_HUGE, F_HUGE, F_HUGE, F_HUGE});
        send_group({F_HUGE, F_ONE, F_ONE, F_ONE}, {F_HUGE, F_ONE, F_TWO, F_ONE});
        send_group({F_TINY, F_TINY, F_TINY, F_TINY}, {F_TINY, F_TINY, F_TINY, F_TINY});
        random_group();
        wait_results();
        report_test("overflow and underflow", err0);

        err0  = error_count;
        bp_on = 1'b1;
        repeat (20) random_group();
        wait_results();
        bp_on = 1'b0;
        if (stall_cycles == 0) begin
            $display("in_ready never fell while out_ready was held back");
            error_count++;
        end
        report_test("back-pressure", err0);

        $display("Tests %0d, results checked %0d, errors %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+test
hdl/fp_pkg.sv
hdl/mac_pkg.sv
hdl/fma_operand_check.sv
hdl/fma_multiply.sv
hdl/fma_accumulate.sv
hdl/fma_result.sv
hdl/fma_cell.sv
test/fma_cell_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fma_cell testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module fma_cell_tb -f compile.f -o fma_cell_sim

./obj_dir/fma_cell_sim | tee "$LOG"

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    echo "fma_cell: pass"
else
    echo "fma_cell: fail"
    exit 1
fi
